// ==== fp27_unit.f ====
+incdir+include
source/fp27_pkg.sv
source/fp27_mul.sv
source/fp27_add.sv
source/fp27_int_convert.sv
source/fp27_inv_sqrt.sv
source/fp27_unit.sv
testbench/fp27_unit_properties.sv
testbench/fp27_unit_tb.sv

// ==== Makefile ====
TOP := fp27_unit_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing -f fp27_unit.f --top-module fp27_unit

sim:
	verilator --binary --timing --assert -Wno-fatal -f fp27_unit.f \
		--top-module $(TOP) -Mdir obj_dir
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "Verification failed" sim.log; then \
		echo "Simulation reported failure"; exit 1; fi
	@grep -q "Verification passed" sim.log || \
		{ echo "Simulation ended without a result"; exit 1; }

clean:
	rm -rf obj_dir sim.log

// ==== testbench/fp27_unit_tb.sv ====
`timescale 1ns/10ps
`include "fp27_params.svh"

module fp27_unit_tb;
	import fp27_pkg::*;

	// One table row
	typedef struct packed {
		logic [`FP27_OP_WIDTH-1:0] op;
		logic [`FP27_WIDTH-1:0] a;
		logic [`FP27_WIDTH-1:0] b;
		logic [`FP27_WIDTH-1:0] expected;
		logic [`FP27_WIDTH-1:0] mask;
	} entry_t;

	// Issued and still in flight
	typedef struct packed {
		logic [`FP27_WIDTH-1:0] expected;
		logic [`FP27_WIDTH-1:0] mask;
		logic [31:0] issue_cycle;
	} pending_t;

	localparam int NUM_ENTRIES = 14;
	localparam int NUM_RANDOM = 200;
	localparam int RESULT_TIMEOUT = 20;
	localparam logic [`FP27_WIDTH-1:0] FULL = '1;
	// Sign, exponent and top four fraction bits
	localparam logic [`FP27_WIDTH-1:0] TOP_BITS = 27'h7ffc000;

	logic iCLK;
	logic rst;
	logic in_valid;
	logic [`FP27_OP_WIDTH-1:0] op;
	fp27_word_u operand_a;
	fp27_word_u operand_b;
	logic out_valid;
	fp27_word_u result;

	entry_t stim_table [NUM_ENTRIES];
	pending_t pending [$];
	logic [`FP27_WIDTH-1:0] observed [$];
	logic [`FP27_WIDTH-1:0] itof_words [NUM_RANDOM];
	int rand_vals [NUM_RANDOM];
	int cycle;
	int checks;
	int errors;
	logic timed_out;

	// 8 ns period
	initial iCLK = 1'b0;
	always #4 iCLK = ~iCLK;

	always @(posedge iCLK) begin
		cycle <= cycle + 1;
	end

	fp27_unit fp27_unit_i (
		.iCLK(iCLK),
		.rst(rst),
		.in_valid(in_valid),
		.op(op),
		.operand_a(operand_a),
		.operand_b(operand_b),
		.out_valid(out_valid),
		.result(result)
	);

	// ========================================================================
	// Word builders and reference model
	// ========================================================================

	function automatic logic [`FP27_WIDTH-1:0] float_word(input logic sign, input int exp,
		input int frac);
		return {sign, 8'(exp), 18'(frac)};
	endfunction

	// Integer view with zero padding
	function automatic logic [`FP27_WIDTH-1:0] int_word(input int value);
		return {{(`FP27_WIDTH-`FP27_INT_WIDTH){1'b0}}, 16'(value)};
	endfunction

	// mag = 2^top * (1 + frac / 2^18), exact for 16-bit magnitudes
	function automatic logic [`FP27_WIDTH-1:0] itof_expected(input int value);
		int mag;
		int top;
		mag = (value < 0) ? -value : value;
		if (mag == 0) begin
			return '0;
		end
		top = 0;
		for (int i = 0; i < `FP27_INT_WIDTH; i++) begin
			if (mag >= (1 << i)) begin
				top = i;
			end
		end
		return float_word(value < 0, `FP27_EXP_BIAS + top,
			(mag - (1 << top)) << (`FP27_FRAC_WIDTH - top));
	endfunction

	task automatic check_value(input string name, input logic [31:0] actual,
		input logic [31:0] expected, input logic [31:0] mask);
		checks++;
		if ((actual & mask) !== (expected & mask)) begin
			errors++;
			$display("CHECK FAILED %s: got %h, expected %h, mask %h", name, actual,
				expected, mask);
		end
	endtask

	// ========================================================================
	// Stimulus table
	// ========================================================================

	task automatic load_table();
		// 1.5 * 2.0 and 1.0 + 0.5
		stim_table[0] = {`FP27_OP_MUL, float_word(0, 127, 'h20000), float_word(0, 128, 0),
			float_word(0, 128, 'h20000), FULL};
		stim_table[1] = {`FP27_OP_ADD, float_word(0, 127, 0), float_word(0, 126, 0),
			float_word(0, 127, 'h20000), FULL};
		// -1.0 * 0.5 and 3.0 + -1.0
		stim_table[2] = {`FP27_OP_MUL, float_word(1, 127, 0), float_word(0, 126, 0),
			float_word(1, 126, 0), FULL};
		stim_table[3] = {`FP27_OP_ADD, float_word(0, 128, 'h20000), float_word(1, 127, 0),
			float_word(0, 128, 0), FULL};
		// Zero operands
		stim_table[4] = {`FP27_OP_MUL, 27'd0, float_word(0, 128, 'h20000), 27'd0, FULL};
		stim_table[5] = {`FP27_OP_ADD, float_word(0, 128, 'h20000), 27'd0,
			float_word(0, 128, 'h20000), FULL};
		// Exact cancellation
		stim_table[6] = {`FP27_OP_ADD, float_word(0, 128, 0), float_word(1, 128, 0),
			27'd0, FULL};
		// 0.75, -2.5, then out of range both ways
		stim_table[7] = {`FP27_OP_FTOI, float_word(0, 126, 'h20000), 27'd0, int_word(0), FULL};
		stim_table[8] = {`FP27_OP_FTOI, float_word(1, 128, 'h10000), 27'd0, int_word(-2), FULL};
		stim_table[9] = {`FP27_OP_FTOI, float_word(0, 150, 0), 27'd0, int_word('h7fff), FULL};
		stim_table[10] = {`FP27_OP_FTOI, float_word(1, 150, 0), 27'd0, int_word(-'h7fff),
			FULL};
		// 1/sqrt(2.25) = 2/3 and 1/sqrt(0.25) = 2
		stim_table[11] = {`FP27_OP_INVSQRT, float_word(0, 128, 'h8000), 27'd0,
			float_word(0, 126, 'h15555), TOP_BITS};
		stim_table[12] = {`FP27_OP_INVSQRT, float_word(0, 125, 0), 27'd0,
			float_word(0, 128, 0), TOP_BITS};
		stim_table[13] = {`FP27_OP_ITOF, int_word(-1), 27'd0, float_word(1, 127, 0), FULL};
	endtask

	// ========================================================================
	// Drive and collect
	// ========================================================================

	// One operation per call, so calls in a row go out back to back
	task automatic issue(input logic [`FP27_OP_WIDTH-1:0] code,
		input logic [`FP27_WIDTH-1:0] a, input logic [`FP27_WIDTH-1:0] b,
		input logic [`FP27_WIDTH-1:0] expected, input logic [`FP27_WIDTH-1:0] mask);
		pending_t item;
		@(posedge iCLK);
		#1;
		in_valid = 1'b1;
		op = code;
		operand_a = a;
		operand_b = b;
		item.expected = expected;
		item.mask = mask;
		item.issue_cycle = cycle;
		pending.push_back(item);
	endtask

	task automatic go_idle();
		@(posedge iCLK);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic collect(input int count);
		pending_t item;
		int waited;
		logic [`FP27_WIDTH-1:0] rounded;
		for (int n = 0; n < count && !timed_out; n++) begin
			waited = 0;
			// Outputs settle well before the falling edge
			do begin
				@(negedge iCLK);
				waited++;
			end while (!out_valid && waited < RESULT_TIMEOUT);
			if (!out_valid) begin
				$display("ERROR: result %0d of %0d missing after %0d cycles", n, count,
					RESULT_TIMEOUT);
				errors++;
				timed_out = 1'b1;
			end else if (pending.size() == 0) begin
				$display("ERROR: out_valid high with no operation in flight");
				errors++;
			end else begin
				item = pending.pop_front();
				observed.push_back(result);
				// Round at the lowest compared bit
				// a value just under a power of two still meets its neighbor
				rounded = result + ((item.mask & -item.mask) >> 1);
				check_value("result", 32'(rounded), 32'(item.expected), 32'(item.mask));
				check_value("latency", 32'(cycle) - item.issue_cycle, `FP27_UNIT_LATENCY, '1);
			end
		end
	endtask

	task automatic report();
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	endtask

	// ========================================================================
	// Main sequence
	// ========================================================================

	initial begin
		void'($urandom(32'h2094_d0a6));
		rst = 1'b1;
		in_valid = 1'b0;
		op = '0;
		operand_a = '0;
		operand_b = '0;
		cycle = 0;
		checks = 0;
		errors = 0;
		timed_out = 1'b0;
		load_table();
		repeat (16) @(posedge iCLK);
		#1;
		rst = 1'b0;

		// Mixed operations, one per cycle
		fork
			begin
				for (int k = 0; k < NUM_ENTRIES; k++) begin
					issue(stim_table[k].op, stim_table[k].a, stim_table[k].b,
						stim_table[k].expected, stim_table[k].mask);
				end
				go_idle();
			end
			collect(NUM_ENTRIES);
		join

		// Random integers to float
		if (!timed_out) begin
			for (int k = 0; k < NUM_RANDOM; k++) begin
				rand_vals[k] = int'($urandom_range(65534)) - 32767;
			end
			observed.delete();
			fork
				begin
					for (int k = 0; k < NUM_RANDOM; k++) begin
						issue(`FP27_OP_ITOF, int_word(rand_vals[k]), '0,
							itof_expected(rand_vals[k]), FULL);
					end
					go_idle();
				end
				collect(NUM_RANDOM);
			join
		end

		// Same words back to integers
		if (!timed_out) begin
			for (int k = 0; k < NUM_RANDOM; k++) begin
				itof_words[k] = observed[k];
			end
			fork
				begin
					for (int k = 0; k < NUM_RANDOM; k++) begin
						issue(`FP27_OP_FTOI, itof_words[k], '0, int_word(rand_vals[k]), FULL);
					end
					go_idle();
				end
				collect(NUM_RANDOM);
			join
		end

		report();
	end

endmodule

// ==== testbench/fp27_unit_properties.sv ====
`timescale 1ns/10ps

module fp27_unit_properties (
	input  logic iCLK,
	input  logic rst,
	input  logic in_valid,
	input  logic out_valid,
	input  fp27_pkg::fp27_word_u result
);

	// ========================================================================
	// Valid pipeline
	// ========================================================================

	// Reset edge empties all five flags
	reset_clears_valid: assert property (@(posedge iCLK) rst |=> !out_valid)
		else $error("out_valid high on the edge after a reset edge");

	// Strobe comes back five edges later, nothing more and nothing less
	valid_latency: assert property (@(posedge iCLK) disable iff (rst)
		1'b1 |-> ##5 (out_valid == $past(in_valid, 5)))
		else $error("out_valid does not match in_valid five cycles earlier");

	// ========================================================================
	// Result word
	// ========================================================================

	result_known: assert property (@(posedge iCLK) disable iff (rst)
		out_valid |-> !$isunknown(result))
		else $error("result has unknown bits while out_valid is high");

endmodule

bind fp27_unit fp27_unit_properties fp27_unit_properties_i (
	.iCLK(iCLK),
	.rst(rst),
	.in_valid(in_valid),
	.out_valid(out_valid),
	.result(result)
);

// ==== source/fp27_unit.sv ====
`timescale 1ns/10ps
`include "fp27_params.svh"

module fp27_unit (
	input  logic iCLK,
	input  logic rst,
	input  logic in_valid,
	input  logic [`FP27_OP_WIDTH-1:0] op,
	input  fp27_pkg::fp27_word_u operand_a,
	input  fp27_pkg::fp27_word_u operand_b,
	output logic out_valid,
	output fp27_pkg::fp27_word_u result
);
	import fp27_pkg::*;

	// Raw unit outputs
	fp27_word_u add_sum;
	fp27_word_u mul_product;
	fp27_word_u itof_word;
	fp27_word_u ftoi_word;
	fp27_word_u inv_word;

	// Delay lines up to the output register
	fp27_word_u mul_d [`FP27_UNIT_LATENCY-1];
	fp27_word_u itof_d [`FP27_UNIT_LATENCY-1];
	fp27_word_u ftoi_d [`FP27_UNIT_LATENCY-1];
	fp27_word_u add_d [`FP27_UNIT_LATENCY-`FP27_ADD_LATENCY-1];
	logic [`FP27_OP_WIDTH-1:0] op_d [`FP27_UNIT_LATENCY-1];

	// Output stage
	fp27_word_u mux_q;
	logic inv_sel_q;
	logic [`FP27_UNIT_LATENCY-1:0] valid_q;

	// ====================================================================
	// Arithmetic units, all fed every cycle
	// ====================================================================

	fp27_add u_add (.iCLK(iCLK), .a(operand_a), .b(operand_b), .sum(add_sum));

	fp27_mul u_mul (.a(operand_a), .b(operand_b), .product(mul_product));

	fp27_int_convert u_convert (.a(operand_a), .to_float(itof_word), .to_int(ftoi_word));

	fp27_inv_sqrt u_inv_sqrt (.iCLK(iCLK), .a(operand_a), .inv_sqrt(inv_word));

	// ====================================================================
	// Latency alignment
	// ====================================================================

	always_ff @(posedge iCLK) begin
		mul_d[0] <= mul_product;
		itof_d[0] <= itof_word;
		ftoi_d[0] <= ftoi_word;
		op_d[0] <= op;
		// Adder already spent two edges
		add_d[0] <= add_sum;
		for (int i = 1; i < `FP27_UNIT_LATENCY-1; i++) begin
			mul_d[i] <= mul_d[i-1];
			itof_d[i] <= itof_d[i-1];
			ftoi_d[i] <= ftoi_d[i-1];
			op_d[i] <= op_d[i-1];
		end
		for (int i = 1; i < `FP27_UNIT_LATENCY-`FP27_ADD_LATENCY-1; i++) begin
			add_d[i] <= add_d[i-1];
		end
	end

	// Fifth edge
	always_ff @(posedge iCLK) begin
		inv_sel_q <= (op_d[`FP27_UNIT_LATENCY-2] == `FP27_OP_INVSQRT);
		case (op_d[`FP27_UNIT_LATENCY-2])
			`FP27_OP_ADD: mux_q <= add_d[`FP27_UNIT_LATENCY-`FP27_ADD_LATENCY-2];
			`FP27_OP_MUL: mux_q <= mul_d[`FP27_UNIT_LATENCY-2];
			`FP27_OP_ITOF: mux_q <= itof_d[`FP27_UNIT_LATENCY-2];
			`FP27_OP_FTOI: mux_q <= ftoi_d[`FP27_UNIT_LATENCY-2];
			default: mux_q <= '0;
		endcase
	end

	// Inverse square root registers its last stage itself
	assign result = inv_sel_q ? inv_word : mux_q;

	// ====================================================================
	// Valid pipeline
	// ====================================================================

	always_ff @(posedge iCLK) begin
		if (rst) begin
			valid_q <= '0;
		end else begin
			valid_q <= {valid_q[`FP27_UNIT_LATENCY-2:0], in_valid};
		end
	end

	assign out_valid = valid_q[`FP27_UNIT_LATENCY-1];

endmodule

// ==== source/fp27_inv_sqrt.sv ====
`timescale 1ns/10ps
`include "fp27_params.svh"

module fp27_inv_sqrt (
	input  logic iCLK,
	input  fp27_pkg::fp27_word_u a,
	output fp27_pkg::fp27_word_u inv_sqrt
);
	import fp27_pkg::*;

	// Seed and its square ahead of edge 1
	fp27_word_u seed;
	fp27_word_u seed_sq;
	fp27_word_u half_a;
	// Seed copies for edges 1 to 5
	fp27_word_u seed_d [5];
	fp27_word_u seed_sq_q;
	fp27_word_u half_a_q;
	// Half operand times seed squared
	fp27_word_u prod;
	fp27_word_u prod_q;
	fp27_word_u neg_prod;
	// Newton correction factor
	fp27_word_u corr;
	fp27_word_u corr_q;

	// Integer trick on the raw bits
	assign seed = `FP27_WIDTH'(`FP27_INVSQRT_MAGIC) - {1'b0, a[`FP27_WIDTH-1:1]};

	// Halving by exponent decrement
	always_comb begin
		half_a = a;
		half_a.f.exp = a.f.exp - 8'd1;
	end

	fp27_mul u_mul_sq (.a(seed), .b(seed), .product(seed_sq));

	fp27_mul u_mul_half (.a(half_a_q), .b(seed_sq_q), .product(prod));

	// Subtraction as addition with flipped sign
	always_comb begin
		neg_prod = prod_q;
		neg_prod.f.sign = ~prod_q.f.sign;
	end

	// Edges 3 and 4, 1.5 minus the product
	fp27_add u_add_corr (
		.iCLK(iCLK),
		.a(neg_prod),
		.b(`FP27_WIDTH'(`FP27_THREE_HALVES)),
		.sum(corr)
	);

	always_ff @(posedge iCLK) begin
		// Edge 1
		seed_d[0] <= seed;
		seed_sq_q <= seed_sq;
		half_a_q <= half_a;
		// Edge 2
		seed_d[1] <= seed_d[0];
		prod_q <= prod;
		// Seed rides along with the adder
		seed_d[2] <= seed_d[1];
		seed_d[3] <= seed_d[2];
		// Edge 5 lines the seed up with the correction
		seed_d[4] <= seed_d[3];
		corr_q <= corr;
	end

	// One Newton step
	fp27_mul u_mul_out (.a(seed_d[4]), .b(corr_q), .product(inv_sqrt));

endmodule

// ==== source/fp27_int_convert.sv ====
`timescale 1ns/10ps
`include "fp27_params.svh"

module fp27_int_convert (
	input  fp27_pkg::fp27_word_u a,
	output fp27_pkg::fp27_word_u to_float,
	output fp27_pkg::fp27_word_u to_int
);

	// ====================================================================
	// Integer to float
	// ====================================================================

	logic int_neg;
	logic [`FP27_INT_WIDTH-1:0] int_mag;
	logic [3:0] lead_pos;
	// Magnitude with room below for the fraction
	logic [`FP27_INT_WIDTH+`FP27_FRAC_WIDTH-1:0] int_aligned;

	// ====================================================================
	// Float to integer
	// ====================================================================

	// 1.frac sitting just above the fraction bits before the shift
	logic [`FP27_INT_WIDTH+`FP27_FRAC_WIDTH-1:0] float_shifted;
	logic [`FP27_INT_WIDTH-1:0] float_mag;

	assign int_neg = a.i.value[`FP27_INT_WIDTH-1];
	// Most negative input still fits as an unsigned magnitude
	assign int_mag = int_neg ? `FP27_INT_WIDTH'(-a.i.value) : `FP27_INT_WIDTH'(a.i.value);

	// Highest set bit gives the exponent
	always_comb begin
		lead_pos = '0;
		for (int i = 0; i < `FP27_INT_WIDTH; i++) begin
			if (int_mag[i]) begin
				lead_pos = 4'(i);
			end
		end
	end

	// Leading one moves to the top bit
	assign int_aligned = {int_mag, {`FP27_FRAC_WIDTH{1'b0}}} << (4'd15 - lead_pos);

	always_comb begin
		if (int_mag == '0) begin
			to_float = '0;
		end else begin
			to_float.f.sign = int_neg;
			to_float.f.exp = `FP27_EXP_WIDTH'(`FP27_EXP_BIAS) + {4'b0000, lead_pos};
			// Bits right below the hidden one
			to_float.f.frac = int_aligned[`FP27_INT_WIDTH+`FP27_FRAC_WIDTH-2:`FP27_INT_WIDTH-1];
		end
	end

	// Shift garbage below bias is never selected
	assign float_shifted = {{(`FP27_INT_WIDTH-1){1'b0}}, 1'b1, a.f.frac}
		<< (a.f.exp - `FP27_EXP_WIDTH'(`FP27_EXP_BIAS));
	// Integer part, fraction bits dropped
	assign float_mag = float_shifted[`FP27_INT_WIDTH+`FP27_FRAC_WIDTH-1:`FP27_FRAC_WIDTH];

	always_comb begin
		to_int = '0;
		if (a.f.exp < `FP27_EXP_WIDTH'(`FP27_EXP_BIAS)) begin
			// Magnitude below one
			to_int.i.value = '0;
		end else if (a.f.exp > `FP27_EXP_WIDTH'(`FP27_EXP_BIAS + `FP27_INT_WIDTH - 2)) begin
			// Out of range so clip
			to_int.i.value = a.f.sign ? -16'sh7fff : 16'sh7fff;
		end else begin
			// Truncation toward zero
			to_int.i.value = a.f.sign ? -$signed(float_mag) : $signed(float_mag);
		end
	end

endmodule

// ==== source/fp27_add.sv ====
`timescale 1ns/10ps
`include "fp27_params.svh"

module fp27_add (
	input  logic iCLK,
	input  fp27_pkg::fp27_word_u a,
	input  fp27_pkg::fp27_word_u b,
	output fp27_pkg::fp27_word_u sum
);
	import fp27_pkg::*;

	// ====================================================================
	// Stage one
	// ====================================================================

	logic [`FP27_FRAC_WIDTH:0] mant_a;
	logic [`FP27_FRAC_WIDTH:0] mant_b;
	logic a_larger;
	logic [`FP27_EXP_WIDTH-1:0] exp_diff;
	// Carry bit, mantissa, then guard bits for the shifted operand
	logic [2*`FP27_FRAC_WIDTH+1:0] big_ext;
	logic [2*`FP27_FRAC_WIDTH+1:0] small_ext;
	logic [2*`FP27_FRAC_WIDTH+1:0] small_shifted;
	logic [2*`FP27_FRAC_WIDTH+1:0] raw_sum;

	// Midway registers
	logic [2*`FP27_FRAC_WIDTH+1:0] raw_sum_q;
	logic [`FP27_EXP_WIDTH-1:0] exp_q;
	logic sign_q;
	logic a_zero_q;
	logic b_zero_q;
	fp27_word_u a_q;
	fp27_word_u b_q;

	// ====================================================================
	// Stage two
	// ====================================================================

	logic [5:0] lead_zeros;
	logic [2*`FP27_FRAC_WIDTH+1:0] norm_shifted;
	logic [`FP27_EXP_WIDTH:0] exp_adj;
	logic underflow;
	fp27_word_u norm_word;

	assign mant_a = {1'b1, a.f.frac};
	assign mant_b = {1'b1, b.f.frac};

	// Equal magnitudes pick b, harmless since the difference is zero
	assign a_larger = (a.f.exp > b.f.exp) ||
		((a.f.exp == b.f.exp) && (a.f.frac > b.f.frac));

	assign exp_diff = a_larger ? (a.f.exp - b.f.exp) : (b.f.exp - a.f.exp);

	assign big_ext = a_larger ? {1'b0, mant_a, {`FP27_FRAC_WIDTH{1'b0}}} :
		{1'b0, mant_b, {`FP27_FRAC_WIDTH{1'b0}}};
	assign small_ext = a_larger ? {1'b0, mant_b, {`FP27_FRAC_WIDTH{1'b0}}} :
		{1'b0, mant_a, {`FP27_FRAC_WIDTH{1'b0}}};

	// Far smaller operand contributes nothing
	assign small_shifted = (exp_diff > 8'd35) ? '0 : (small_ext >> exp_diff);

	// Opposite signs subtract, larger minus smaller stays positive
	assign raw_sum = (a.f.sign ^ b.f.sign) ? (big_ext - small_shifted) :
		(big_ext + small_shifted);

	always_ff @(posedge iCLK) begin
		raw_sum_q <= raw_sum;
		exp_q <= a_larger ? a.f.exp : b.f.exp;
		sign_q <= a_larger ? a.f.sign : b.f.sign;
		a_zero_q <= (a.f.exp == '0);
		b_zero_q <= (b.f.exp == '0);
		// Kept whole for the zero operand bypass
		a_q <= a;
		b_q <= b;
	end

	// Leading one search, lowest set bit first so the highest wins
	always_comb begin
		lead_zeros = 6'd38;
		for (int i = 0; i < 2*`FP27_FRAC_WIDTH+2; i++) begin
			if (raw_sum_q[i]) begin
				lead_zeros = 6'(2*`FP27_FRAC_WIDTH+1 - i);
			end
		end
	end

	// Leading one lands in the top bit
	assign norm_shifted = raw_sum_q << lead_zeros;

	// One leading zero is the normal position
	assign exp_adj = {1'b0, exp_q} + 9'd1 - {3'b000, lead_zeros};
	assign underflow = {3'b000, lead_zeros} >= ({1'b0, exp_q} + 9'd1);

	always_comb begin
		if (a_zero_q && b_zero_q) begin
			norm_word = '0;
		end else if (a_zero_q) begin
			norm_word = b_q;
		end else if (b_zero_q) begin
			norm_word = a_q;
		end else if ((raw_sum_q == '0) || underflow) begin
			// Exact cancellation or too small to encode
			norm_word = '0;
		end else begin
			norm_word.f.sign = sign_q;
			norm_word.f.exp = exp_adj[`FP27_EXP_WIDTH-1:0];
			norm_word.f.frac = norm_shifted[2*`FP27_FRAC_WIDTH:`FP27_FRAC_WIDTH+1];
		end
	end

	// Second edge
	always_ff @(posedge iCLK) begin
		sum <= norm_word;
	end

endmodule

// ==== source/fp27_mul.sv ====
`timescale 1ns/10ps
`include "fp27_params.svh"

module fp27_mul (
	input  fp27_pkg::fp27_word_u a,
	input  fp27_pkg::fp27_word_u b,
	output fp27_pkg::fp27_word_u product
);

	// Mantissas with the hidden one restored
	logic [`FP27_FRAC_WIDTH:0] mant_a;
	logic [`FP27_FRAC_WIDTH:0] mant_b;
	// Full product lies in [1, 4)
	logic [2*`FP27_FRAC_WIDTH+1:0] mant_prod;
	logic [`FP27_EXP_WIDTH:0] exp_sum;
	logic [`FP27_EXP_WIDTH:0] exp_biased;
	logic [`FP27_FRAC_WIDTH-1:0] frac_norm;
	logic carry;
	logic underflow;

	assign mant_a = {1'b1, a.f.frac};
	assign mant_b = {1'b1, b.f.frac};
	assign mant_prod = mant_a * mant_b;

	// Top bit set means product is 2 or more
	assign carry = mant_prod[2*`FP27_FRAC_WIDTH+1];

	// Both biases present in the sum, remove one
	assign exp_sum = a.f.exp + b.f.exp;
	assign exp_biased = exp_sum - (`FP27_EXP_WIDTH+1)'(`FP27_EXP_BIAS)
		+ {{`FP27_EXP_WIDTH{1'b0}}, carry};

	// Exponent would drop to zero or below
	assign underflow = exp_sum <= (`FP27_EXP_WIDTH+1)'(`FP27_EXP_BIAS);

	// Drop the leading one and keep the next 18 bits
	assign frac_norm = carry ?
		mant_prod[2*`FP27_FRAC_WIDTH:`FP27_FRAC_WIDTH+1] :
		mant_prod[2*`FP27_FRAC_WIDTH-1:`FP27_FRAC_WIDTH];

	always_comb begin
		// Zero exponent on either side means a zero operand
		if (underflow || (a.f.exp == '0) || (b.f.exp == '0)) begin
			product = '0;
		end else begin
			product.f.sign = a.f.sign ^ b.f.sign;
			product.f.exp = exp_biased[`FP27_EXP_WIDTH-1:0];
			product.f.frac = frac_norm;
		end
	end

endmodule

// ==== source/fp27_pkg.sv ====
`include "fp27_params.svh"

package fp27_pkg;

	// ====================================================================
	// Operand word and its two views
	// ====================================================================

	// Float view
	// value is sign times 2^(exp - bias) times 1.frac
	typedef struct packed {
		logic sign;
		logic [`FP27_EXP_WIDTH-1:0] exp;
		logic [`FP27_FRAC_WIDTH-1:0] frac;
	} fp27_float_t;

	// Integer view
	// Upper bits are padding and hold zero on results
	typedef struct packed {
		logic [`FP27_WIDTH-`FP27_INT_WIDTH-1:0] pad;
		logic signed [`FP27_INT_WIDTH-1:0] value;
	} fp27_int_t;

	// Same 27 bits decoded either way
	typedef union packed {
		fp27_float_t f;
		fp27_int_t i;
	} fp27_word_u;

endpackage

// ==== include/fp27_params.svh ====
`ifndef FP27_PARAMS_SVH
`define FP27_PARAMS_SVH

// ========================================================================
// Number format
// ========================================================================

// Sign plus exponent plus fraction
`define FP27_WIDTH 27
`define FP27_EXP_WIDTH 8
`define FP27_FRAC_WIDTH 18
`define FP27_EXP_BIAS 127
// Integer side of the conversions
`define FP27_INT_WIDTH 16

// Seed constant for the inverse square root
`define FP27_INVSQRT_MAGIC 49920718
// Encoded 1.5 for the Newton step
`define FP27_THREE_HALVES 33423360

// Pipeline depths in clock cycles
`define FP27_ADD_LATENCY 2
`define FP27_UNIT_LATENCY 5

// Operation codes
`define FP27_OP_WIDTH 3
`define FP27_OP_ADD 3'd0
`define FP27_OP_MUL 3'd1
`define FP27_OP_ITOF 3'd2
`define FP27_OP_FTOI 3'd3
`define FP27_OP_INVSQRT 3'd4

`endif
